// File: dual_issue_pkg.sv
`default_nettype none

package dual_issue_pkg;

    // Widths ------------------------
    localparam int XLEN        = 32;
    localparam int REG_AW      = 5;
    localparam int PC_W        = 10;   // Instruction address width.
    localparam int DMEM_AW     = 8;
    localparam int DMEM_DEPTH  = 256;
    localparam int IMM_W       = 16;
    localparam int OP_W        = 4;
    localparam int ISSUE_WIDTH = 2;    // Slots per issued pair.

    typedef logic [XLEN-1:0]    word_t;
    typedef logic [REG_AW-1:0]  reg_addr_t;
    typedef logic [PC_W-1:0]    pc_t;
    typedef logic [DMEM_AW-1:0] dmem_addr_t;
    typedef logic [IMM_W-1:0]   imm_t;     // Sign-extended before use.
    typedef logic [OP_W-1:0]    opcode_t;

    // Opcodes -----------------------
    localparam opcode_t OP_NOP  = 4'd0;
    localparam opcode_t OP_ADD  = 4'd1;
    localparam opcode_t OP_SUB  = 4'd2;
    localparam opcode_t OP_AND  = 4'd3;
    localparam opcode_t OP_OR   = 4'd4;
    localparam opcode_t OP_SLT  = 4'd5;    // Signed compare.
    localparam opcode_t OP_ADDI = 4'd6;
    localparam opcode_t OP_LW   = 4'd7;
    localparam opcode_t OP_SW   = 4'd8;
    localparam opcode_t OP_JAL  = 4'd9;    // Link only.

endpackage

`default_nettype wire

// File: stage_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// Result tap of one pipeline stage, one entry per slot.
interface stage_tap_if;
    import dual_issue_pkg::*;

    logic      valid0;     // Slot 0 writes a nonzero rd.
    reg_addr_t rd0;
    word_t     value0;
    logic      is_load0;   // Value is still the address.
    logic      valid1;
    reg_addr_t rd1;
    word_t     value1;
    logic      is_load1;

    modport producer (output valid0, rd0, value0, is_load0,
                      output valid1, rd1, value1, is_load1);
    modport consumer (input  valid0, rd0, value0, is_load0,
                      input  valid1, rd1, value1, is_load1);
endinterface

// Writeback bus into the register file.
interface wb_bus_if;
    import dual_issue_pkg::*;

    logic      wb_valid0;
    reg_addr_t wb_rd0;
    word_t     wb_data0;
    logic      wb_valid1;
    reg_addr_t wb_rd1;
    word_t     wb_data1;

    modport source (output wb_valid0, wb_rd0, wb_data0, wb_valid1, wb_rd1, wb_data1);
    modport sink   (input  wb_valid0, wb_rd0, wb_data0, wb_valid1, wb_rd1, wb_data1);
endinterface

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                      clk,
    input  logic                      rst_n,
    input  dual_issue_pkg::reg_addr_t rs0,
    input  dual_issue_pkg::reg_addr_t rt0,
    input  dual_issue_pkg::reg_addr_t rs1,
    input  dual_issue_pkg::reg_addr_t rt1,
    output dual_issue_pkg::word_t     rs0_val,
    output dual_issue_pkg::word_t     rt0_val,
    output dual_issue_pkg::word_t     rs1_val,
    output dual_issue_pkg::word_t     rt1_val,
    wb_bus_if.sink                    wb
);
    import dual_issue_pkg::*;

    word_t regs [2**REG_AW];

    // Slot 1 is written last, so it wins a same-index write.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb.wb_valid0) regs[wb.wb_rd0] <= wb.wb_data0;
            if (wb.wb_valid1) regs[wb.wb_rd1] <= wb.wb_data1;
        end
    end

    // Register 0 reads as zero.
    assign rs0_val = (rs0 == '0) ? '0 : regs[rs0];
    assign rt0_val = (rt0 == '0) ? '0 : regs[rt0];
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rt1_val = (rt1 == '0) ? '0 : regs[rt1];

endmodule

`default_nettype wire

// File: operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      issue_valid,
    input  dual_issue_pkg::reg_addr_t rs0,
    input  dual_issue_pkg::reg_addr_t rt0,
    input  dual_issue_pkg::reg_addr_t rs1,
    input  dual_issue_pkg::reg_addr_t rt1,
    input  dual_issue_pkg::word_t     rs0_val,
    input  dual_issue_pkg::word_t     rt0_val,
    input  dual_issue_pkg::word_t     rs1_val,
    input  dual_issue_pkg::word_t     rt1_val,
    stage_tap_if.consumer             ex_tap,
    stage_tap_if.consumer             mem_tap,
    wb_bus_if.sink                    wb,
    output dual_issue_pkg::word_t     fwd_rs0,
    output dual_issue_pkg::word_t     fwd_rt0,
    output dual_issue_pkg::word_t     fwd_rs1,
    output dual_issue_pkg::word_t     fwd_rt1
);
    import dual_issue_pkg::*;

    reg_addr_t idx    [2*ISSUE_WIDTH];
    word_t     rf_val [2*ISSUE_WIDTH];
    word_t     fwd    [2*ISSUE_WIDTH];

    // Sources in priority order, index 0 highest.
    logic      src_valid [3*ISSUE_WIDTH];
    reg_addr_t src_rd    [3*ISSUE_WIDTH];
    word_t     src_val   [3*ISSUE_WIDTH];
    logic      src_load  [2*ISSUE_WIDTH];  // EX and MEM entries only.
    logic      load_use;
    logic      tap_rd_zero;

    assign idx    = '{rs0, rt0, rs1, rt1};
    assign rf_val = '{rs0_val, rt0_val, rs1_val, rt1_val};

    assign src_valid = '{ex_tap.valid1, ex_tap.valid0, mem_tap.valid1, mem_tap.valid0,
                         wb.wb_valid1, wb.wb_valid0};
    assign src_rd    = '{ex_tap.rd1, ex_tap.rd0, mem_tap.rd1, mem_tap.rd0,
                         wb.wb_rd1, wb.wb_rd0};
    assign src_val   = '{ex_tap.value1, ex_tap.value0, mem_tap.value1, mem_tap.value0,
                         wb.wb_data1, wb.wb_data0};
    assign src_load  = '{ex_tap.is_load1, ex_tap.is_load0,
                         mem_tap.is_load1, mem_tap.is_load0};

    // Walk from lowest priority up so the best match is applied last.
    always_comb begin
        load_use    = 1'b0;
        tap_rd_zero = 1'b0;
        for (int k = 0; k < 2*ISSUE_WIDTH; k++) begin
            fwd[k] = rf_val[k];
            for (int s = 3*ISSUE_WIDTH - 1; s >= 0; s--) begin
                if (src_valid[s] && idx[k] != '0 && src_rd[s] == idx[k]) begin
                    fwd[k] = src_val[s];
                    if (s < 2*ISSUE_WIDTH && src_load[s]) load_use = 1'b1;
                end
            end
        end
        for (int s = 0; s < 2*ISSUE_WIDTH; s++) begin
            if (src_valid[s] && src_rd[s] == '0) tap_rd_zero = 1'b1;
        end
    end

    assign fwd_rs0 = fwd[0];
    assign fwd_rt0 = fwd[1];
    assign fwd_rs1 = fwd[2];
    assign fwd_rt1 = fwd[3];

    // Checks ------------------------
    // A load's word exists only from writeback on.
    a_load_use: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> !load_use)
        else $error("operand_forward: operand depends on a load still in EX or MEM");

    a_tap_rd: assert property (@(posedge clk) disable iff (!rst_n) !tap_rd_zero)
        else $error("operand_forward: valid tap entry targets register 0");

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  dual_issue_pkg::opcode_t op,
    input  dual_issue_pkg::word_t   a,
    input  dual_issue_pkg::word_t   b,
    input  dual_issue_pkg::imm_t    imm,
    input  dual_issue_pkg::pc_t     pc,
    output dual_issue_pkg::word_t   result
);
    import dual_issue_pkg::*;

    word_t imm_ext;
    pc_t   link;

    assign imm_ext = {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
    assign link    = pc + pc_t'(1);   // Return address of a jal.

    always_comb begin
        case (op)
            OP_ADD:              result = a + b;
            OP_SUB:              result = a - b;
            OP_AND:              result = a & b;
            OP_OR:               result = a | b;
            OP_SLT:              result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            OP_ADDI, OP_LW, OP_SW: result = a + imm_ext;   // Also the memory address.
            OP_JAL:              result = {{(XLEN-PC_W){1'b0}}, link};
            default:             result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      issue_valid,
    input  dual_issue_pkg::opcode_t   op0,
    input  dual_issue_pkg::opcode_t   op1,
    input  dual_issue_pkg::reg_addr_t rd0,
    input  dual_issue_pkg::reg_addr_t rd1,
    input  dual_issue_pkg::imm_t      imm0,
    input  dual_issue_pkg::imm_t      imm1,
    input  dual_issue_pkg::pc_t       pc0,
    input  dual_issue_pkg::pc_t       pc1,
    input  dual_issue_pkg::word_t     fwd_rs0,
    input  dual_issue_pkg::word_t     fwd_rt0,
    input  dual_issue_pkg::word_t     fwd_rs1,
    input  dual_issue_pkg::word_t     fwd_rt1,
    stage_tap_if.producer             ex_tap,
    output dual_issue_pkg::opcode_t   ex_op0,
    output dual_issue_pkg::opcode_t   ex_op1,
    output dual_issue_pkg::word_t     ex_res0,
    output dual_issue_pkg::word_t     ex_res1,
    output dual_issue_pkg::word_t     ex_store0,
    output dual_issue_pkg::word_t     ex_store1
);
    import dual_issue_pkg::*;

    opcode_t   op0_q, op1_q;
    logic      wr0_q, wr1_q;
    reg_addr_t rd0_q, rd1_q;
    imm_t      imm0_q, imm1_q;
    pc_t       pc0_q, pc1_q;
    word_t     a0_q, b0_q, a1_q, b1_q;

    function automatic logic writes_reg(opcode_t op);
        return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SLT, OP_ADDI, OP_LW, OP_JAL};
    endfunction

    // ID/EX control -----------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op0_q <= OP_NOP;
            op1_q <= OP_NOP;
            wr0_q <= 1'b0;
            wr1_q <= 1'b0;
        end else begin
            op0_q <= issue_valid ? op0 : OP_NOP;   // Bubble when not issued.
            op1_q <= issue_valid ? op1 : OP_NOP;
            wr0_q <= issue_valid && writes_reg(op0) && (rd0 != '0);
            wr1_q <= issue_valid && writes_reg(op1) && (rd1 != '0);
        end
    end

    // ID/EX payload.
    always_ff @(posedge clk) begin
        rd0_q  <= rd0;
        rd1_q  <= rd1;
        imm0_q <= imm0;
        imm1_q <= imm1;
        pc0_q  <= pc0;
        pc1_q  <= pc1;
        a0_q   <= fwd_rs0;
        b0_q   <= fwd_rt0;
        a1_q   <= fwd_rs1;
        b1_q   <= fwd_rt1;
    end

    alu alu0_inst (.op(op0_q), .a(a0_q), .b(b0_q), .imm(imm0_q), .pc(pc0_q), .result(ex_res0));
    alu alu1_inst (.op(op1_q), .a(a1_q), .b(b1_q), .imm(imm1_q), .pc(pc1_q), .result(ex_res1));

    assign ex_op0    = op0_q;
    assign ex_op1    = op1_q;
    assign ex_store0 = b0_q;   // rt carries the store data.
    assign ex_store1 = b1_q;

    assign ex_tap.valid0   = wr0_q;
    assign ex_tap.rd0      = rd0_q;
    assign ex_tap.value0   = ex_res0;
    assign ex_tap.is_load0 = (op0_q == OP_LW);
    assign ex_tap.valid1   = wr1_q;
    assign ex_tap.rd1      = rd1_q;
    assign ex_tap.value1   = ex_res1;
    assign ex_tap.is_load1 = (op1_q == OP_LW);

endmodule

`default_nettype wire

// File: data_memory.sv
`timescale 1ns/1ps
`default_nettype none

module data_memory (
    input  logic                       clk,
    input  dual_issue_pkg::dmem_addr_t addr_a,
    input  dual_issue_pkg::dmem_addr_t addr_b,
    input  dual_issue_pkg::word_t      wdata_a,
    input  dual_issue_pkg::word_t      wdata_b,
    input  logic                       we_a,
    input  logic                       we_b,
    output dual_issue_pkg::word_t      q_a,
    output dual_issue_pkg::word_t      q_b
);
    import dual_issue_pkg::*;

    word_t mem [DMEM_DEPTH];

    // Reads see the old word; port b is written last and wins.
    always_ff @(posedge clk) begin
        q_a <= mem[addr_a];
        q_b <= mem[addr_b];
        if (we_a) mem[addr_a] <= wdata_a;
        if (we_b) mem[addr_b] <= wdata_b;
    end

    a_we_known: assert property (@(posedge clk) !$isunknown({we_a, we_b}))
        else $error("data_memory: write enable unknown");

endmodule

`default_nettype wire

// File: mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  dual_issue_pkg::opcode_t ex_op0,
    input  dual_issue_pkg::opcode_t ex_op1,
    input  dual_issue_pkg::word_t   ex_res0,
    input  dual_issue_pkg::word_t   ex_res1,
    input  dual_issue_pkg::word_t   ex_store0,
    input  dual_issue_pkg::word_t   ex_store1,
    stage_tap_if.consumer           ex_tap,
    stage_tap_if.producer           mem_tap,
    wb_bus_if.source                wb
);
    import dual_issue_pkg::*;

    // EX/MEM
    logic      m_valid0, m_valid1, m_load0, m_load1, m_store0, m_store1;
    reg_addr_t m_rd0, m_rd1;
    word_t     m_res0, m_res1, m_sdata0, m_sdata1;
    // MEM/WB
    logic      w_valid0, w_valid1, w_load0, w_load1;
    reg_addr_t w_rd0, w_rd1;
    word_t     w_res0, w_res1;
    word_t     q0, q1;

    // Pipeline control --------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            {m_valid0, m_valid1, m_load0, m_load1, m_store0, m_store1} <= '0;
            {w_valid0, w_valid1, w_load0, w_load1} <= '0;
        end else begin
            m_valid0 <= ex_tap.valid0;
            m_valid1 <= ex_tap.valid1;
            m_load0  <= (ex_op0 == OP_LW);
            m_load1  <= (ex_op1 == OP_LW);
            m_store0 <= (ex_op0 == OP_SW);
            m_store1 <= (ex_op1 == OP_SW);
            w_valid0 <= m_valid0;
            w_valid1 <= m_valid1;
            w_load0  <= m_load0;
            w_load1  <= m_load1;
        end
    end

    always_ff @(posedge clk) begin
        m_rd0    <= ex_tap.rd0;
        m_rd1    <= ex_tap.rd1;
        m_res0   <= ex_res0;
        m_res1   <= ex_res1;
        m_sdata0 <= ex_store0;
        m_sdata1 <= ex_store1;
        w_rd0    <= m_rd0;
        w_rd1    <= m_rd1;
        w_res0   <= m_res0;
        w_res1   <= m_res1;
    end

    // Slot 1 on port b, so its store wins a collision.
    data_memory data_memory_inst (
        .clk     (clk),
        .addr_a  (m_res0[DMEM_AW-1:0]),
        .addr_b  (m_res1[DMEM_AW-1:0]),
        .wdata_a (m_sdata0),
        .wdata_b (m_sdata1),
        .we_a    (m_store0),
        .we_b    (m_store1),
        .q_a     (q0),
        .q_b     (q1)
    );

    assign mem_tap.valid0   = m_valid0;
    assign mem_tap.rd0      = m_rd0;
    assign mem_tap.value0   = m_res0;
    assign mem_tap.is_load0 = m_load0;
    assign mem_tap.valid1   = m_valid1;
    assign mem_tap.rd1      = m_rd1;
    assign mem_tap.value1   = m_res1;
    assign mem_tap.is_load1 = m_load1;

    // Writeback select ----------------
    assign wb.wb_valid0 = w_valid0;
    assign wb.wb_rd0    = w_rd0;
    assign wb.wb_data0  = w_load0 ? q0 : w_res0;
    assign wb.wb_valid1 = w_valid1;
    assign wb.wb_rd1    = w_rd1;
    assign wb.wb_data1  = w_load1 ? q1 : w_res1;

endmodule

`default_nettype wire

// File: dual_issue_core.sv
`timescale 1ns/1ps
`default_nettype none

module dual_issue_core (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      issue_valid,
    input  dual_issue_pkg::opcode_t   op0,
    input  dual_issue_pkg::opcode_t   op1,
    input  dual_issue_pkg::reg_addr_t rs0,
    input  dual_issue_pkg::reg_addr_t rt0,
    input  dual_issue_pkg::reg_addr_t rd0,
    input  dual_issue_pkg::reg_addr_t rs1,
    input  dual_issue_pkg::reg_addr_t rt1,
    input  dual_issue_pkg::reg_addr_t rd1,
    input  dual_issue_pkg::imm_t      imm0,
    input  dual_issue_pkg::imm_t      imm1,
    input  dual_issue_pkg::pc_t       pc0,
    input  dual_issue_pkg::pc_t       pc1,
    output logic                      wb_valid0,
    output logic                      wb_valid1,
    output dual_issue_pkg::reg_addr_t wb_rd0,
    output dual_issue_pkg::reg_addr_t wb_rd1,
    output dual_issue_pkg::word_t     wb_data0,
    output dual_issue_pkg::word_t     wb_data1
);
    import dual_issue_pkg::*;

    word_t   rs0_val, rt0_val, rs1_val, rt1_val;   // Register file reads.
    word_t   fwd_rs0, fwd_rt0, fwd_rs1, fwd_rt1;   // After forwarding.
    opcode_t ex_op0, ex_op1;
    word_t   ex_res0, ex_res1, ex_store0, ex_store1;

    stage_tap_if ex_tap ();
    stage_tap_if mem_tap ();
    wb_bus_if    wb ();

    // Issue -------------------------
    reg_file reg_file_inst (
        .clk (clk), .rst_n (rst_n),
        .rs0 (rs0), .rt0 (rt0), .rs1 (rs1), .rt1 (rt1),
        .rs0_val (rs0_val), .rt0_val (rt0_val), .rs1_val (rs1_val), .rt1_val (rt1_val),
        .wb  (wb.sink)
    );

    operand_forward operand_forward_inst (
        .clk (clk), .rst_n (rst_n), .issue_valid (issue_valid),
        .rs0 (rs0), .rt0 (rt0), .rs1 (rs1), .rt1 (rt1),
        .rs0_val (rs0_val), .rt0_val (rt0_val), .rs1_val (rs1_val), .rt1_val (rt1_val),
        .ex_tap (ex_tap.consumer), .mem_tap (mem_tap.consumer), .wb (wb.sink),
        .fwd_rs0 (fwd_rs0), .fwd_rt0 (fwd_rt0), .fwd_rs1 (fwd_rs1), .fwd_rt1 (fwd_rt1)
    );

    // Execute and memory ------------
    execute_stage execute_stage_inst (
        .clk (clk), .rst_n (rst_n), .issue_valid (issue_valid),
        .op0 (op0), .op1 (op1), .rd0 (rd0), .rd1 (rd1),
        .imm0 (imm0), .imm1 (imm1), .pc0 (pc0), .pc1 (pc1),
        .fwd_rs0 (fwd_rs0), .fwd_rt0 (fwd_rt0), .fwd_rs1 (fwd_rs1), .fwd_rt1 (fwd_rt1),
        .ex_tap (ex_tap.producer),
        .ex_op0 (ex_op0), .ex_op1 (ex_op1), .ex_res0 (ex_res0), .ex_res1 (ex_res1),
        .ex_store0 (ex_store0), .ex_store1 (ex_store1)
    );

    mem_wb_stage mem_wb_stage_inst (
        .clk (clk), .rst_n (rst_n),
        .ex_op0 (ex_op0), .ex_op1 (ex_op1), .ex_res0 (ex_res0), .ex_res1 (ex_res1),
        .ex_store0 (ex_store0), .ex_store1 (ex_store1),
        .ex_tap (ex_tap.consumer), .mem_tap (mem_tap.producer), .wb (wb.source)
    );

    assign wb_valid0 = wb.wb_valid0;
    assign wb_valid1 = wb.wb_valid1;
    assign wb_rd0    = wb.wb_rd0;
    assign wb_rd1    = wb.wb_rd1;
    assign wb_data0  = wb.wb_data0;
    assign wb_data1  = wb.wb_data1;

endmodule

`default_nettype wire

// File: tb_dual_issue_prog.svh
// Pair: iv, then op rs rt rd imm pc for slot 0 and slot 1.
// Expect: valid rd data for slot 0, then for slot 1.

// Reset and ALU ----------------
add_pair(0, OP_NOP, 0, 0, 0, 0, 0, OP_NOP, 0, 0, 0, 0, 1);
add_expect(0, 0, 0, 0, 0, 0);
add_pair(1, OP_ADDI, 0, 0, 1, 5, 2, OP_ADDI, 0, 0, 2, -3, 3);
add_expect(1, 1, 'h5, 1, 2, 'hFFFFFFFD);
add_pair(1, OP_ADD, 1, 2, 3, 0, 4, OP_SUB, 1, 2, 4, 0, 5);       // From EX.
add_expect(1, 3, 'h2, 1, 4, 'h8);
add_pair(1, OP_SLT, 2, 1, 5, 0, 6, OP_OR, 3, 4, 6, 0, 7);        // MEM and EX.
add_expect(1, 5, 'h1, 1, 6, 'hA);
add_pair(1, OP_AND, 2, 4, 7, 0, 8, OP_SLT, 1, 2, 8, 0, 9);       // WB and MEM.
add_expect(1, 7, 'h8, 1, 8, 'h0);

// Same rd and in-pair reads ------
add_pair(1, OP_ADDI, 0, 0, 9, 100, 10, OP_ADDI, 0, 0, 9, 200, 11);
add_expect(1, 9, 'h64, 1, 9, 'hC8);
add_pair(1, OP_ADDI, 0, 0, 1, 'h10, 12, OP_ADD, 1, 9, 12, 0, 13);  // Slot 1 sees old r1.
add_expect(1, 1, 'h10, 1, 12, 'hCD);
add_pair(1, OP_ADD, 9, 1, 13, 0, 14, OP_SUB, 12, 0, 14, 0, 15);
add_expect(1, 13, 'hD8, 1, 14, 'hCD);

// Stores, then loads ------------
add_pair(1, OP_SW, 0, 13, 0, 'h20, 16, OP_SW, 1, 14, 0, 'h21, 17);
add_expect(0, 0, 0, 0, 0, 0);
add_pair(1, OP_SW, 0, 3, 0, 'h40, 18, OP_SW, 0, 4, 0, 'h40, 19);   // Slot 1 word stays.
add_expect(0, 0, 0, 0, 0, 0);
add_pair(1, OP_NOP, 0, 0, 0, 0, 20, OP_NOP, 0, 0, 0, 0, 21);
add_expect(0, 0, 0, 0, 0, 0);
add_pair(1, OP_LW, 0, 0, 15, 'h20, 22, OP_LW, 1, 0, 16, 'h21, 23);
add_expect(1, 15, 'hD8, 1, 16, 'hCD);
add_pair(1, OP_LW, 0, 0, 17, 'h40, 24, OP_JAL, 0, 0, 31, 0, 25);
add_expect(1, 17, 'h8, 1, 31, 'h1A);

// Link and register 0 -----------
add_pair(1, OP_JAL, 0, 0, 0, 0, 26, OP_ADDI, 0, 0, 18, 'h7FFF, 27);
add_expect(0, 0, 0, 1, 18, 'h7FFF);
add_pair(1, OP_ADD, 15, 16, 19, 0, 28, OP_OR, 31, 0, 20, 0, 29);
add_expect(1, 19, 'h1A5, 1, 20, 'h1A);
add_pair(1, OP_ADD, 0, 18, 21, 0, 30, OP_ADD, 17, 0, 22, 0, 31);
add_expect(1, 21, 'h7FFF, 1, 22, 'h8);
add_pair(0, OP_ADDI, 0, 0, 23, 5, 32, OP_ADDI, 0, 0, 24, 6, 33);   // Dropped, not issued.
add_expect(0, 0, 0, 0, 0, 0);
add_pair(1, OP_ADD, 23, 9, 25, 0, 34, OP_ADDI, 0, 0, 26, -1, 35);
add_expect(1, 25, 'hC8, 1, 26, 'hFFFFFFFF);

// File: tb_dual_issue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dual_issue;
    import dual_issue_pkg::*;

    localparam int          CLK_HALF_NS  = 10;
    localparam int          RESET_CYCLES = 4;
    localparam int          PIPE_DEPTH   = 3;    // Falling edges from drive to writeback.
    localparam int          WAIT_LIMIT   = 20;
    localparam int          MAX_CYCLES   = 500;
    localparam int unsigned SEED         = 32'h96f7b40b;

    typedef struct packed {
        logic      iv;
        opcode_t   op0, op1;
        reg_addr_t rs0, rt0, rd0, rs1, rt1, rd1;
        imm_t      imm0, imm1;
        pc_t       pc0, pc1;
        logic      ev0, ev1;             // Expected writeback.
        reg_addr_t erd0, erd1;
        word_t     edata0, edata1;
    } row_t;

    logic      clk, rst_n, issue_valid;
    opcode_t   op0, op1;
    reg_addr_t rs0, rt0, rd0, rs1, rt1, rd1;
    imm_t      imm0, imm1;
    pc_t       pc0, pc1;
    logic      wb_valid0, wb_valid1;
    reg_addr_t wb_rd0, wb_rd1;
    word_t     wb_data0, wb_data1;

    row_t rows [$];
    row_t pending;
    int   run_cycles;

    dual_issue_core dual_issue_core_inst (
        .clk (clk), .rst_n (rst_n), .issue_valid (issue_valid),
        .op0 (op0), .op1 (op1), .rs0 (rs0), .rt0 (rt0), .rd0 (rd0),
        .rs1 (rs1), .rt1 (rt1), .rd1 (rd1), .imm0 (imm0), .imm1 (imm1),
        .pc0 (pc0), .pc1 (pc1),
        .wb_valid0 (wb_valid0), .wb_valid1 (wb_valid1), .wb_rd0 (wb_rd0), .wb_rd1 (wb_rd1),
        .wb_data0 (wb_data0), .wb_data1 (wb_data1)
    );

    initial clk = 1'b0;
    always #(CLK_HALF_NS) clk = ~clk;

    always @(posedge clk) begin
        if (!rst_n) run_cycles <= 0;
        else        run_cycles <= run_cycles + 1;   // Cycles since reset release.
    end

    // Table building ----------------
    task automatic add_pair(input int iv, input opcode_t o0, input int s0, input int t0,
                            input int d0, input int i0, input int p0, input opcode_t o1,
                            input int s1, input int t1, input int d1, input int i1,
                            input int p1);
        pending      = '0;
        pending.iv   = (iv != 0);
        pending.op0  = o0;
        pending.rs0  = reg_addr_t'(s0);
        pending.rt0  = reg_addr_t'(t0);
        pending.rd0  = reg_addr_t'(d0);
        pending.imm0 = imm_t'(i0);
        pending.pc0  = pc_t'(p0);
        pending.op1  = o1;
        pending.rs1  = reg_addr_t'(s1);
        pending.rt1  = reg_addr_t'(t1);
        pending.rd1  = reg_addr_t'(d1);
        pending.imm1 = imm_t'(i1);
        pending.pc1  = pc_t'(p1);
    endtask

    task automatic add_expect(input int v0, input int d0, input int x0,
                              input int v1, input int d1, input int x1);
        pending.ev0    = (v0 != 0);
        pending.erd0   = reg_addr_t'(d0);
        pending.edata0 = word_t'(x0);
        pending.ev1    = (v1 != 0);
        pending.erd1   = reg_addr_t'(d1);
        pending.edata1 = word_t'(x1);
        rows.push_back(pending);
    endtask

    task automatic build_table();
        `include "tb_dual_issue_prog.svh"
    endtask

    // Checks ------------------------
    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on the first error.");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %0d got %0d", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected 0x%08h got 0x%08h", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_row(input int k, input row_t r);
        check_bit($sformatf("row %0d wb_valid0", k), r.ev0, wb_valid0);
        check_bit($sformatf("row %0d wb_valid1", k), r.ev1, wb_valid1);
        if (r.ev0) begin
            check_reg($sformatf("row %0d wb_rd0", k), r.erd0, wb_rd0);
            check_word($sformatf("row %0d wb_data0", k), r.edata0, wb_data0);
        end
        if (r.ev1) begin
            check_reg($sformatf("row %0d wb_rd1", k), r.erd1, wb_rd1);
            check_word($sformatf("row %0d wb_data1", k), r.edata1, wb_data1);
        end
    endtask

    // NOP immediates are don't-care, so they get random fill.
    task automatic drive_row(input row_t r);
        issue_valid <= r.iv;
        op0  <= r.op0;
        rs0  <= r.rs0;
        rt0  <= r.rt0;
        rd0  <= r.rd0;
        imm0 <= (r.op0 == OP_NOP) ? imm_t'($urandom) : r.imm0;
        pc0  <= r.pc0;
        op1  <= r.op1;
        rs1  <= r.rs1;
        rt1  <= r.rt1;
        rd1  <= r.rd1;
        imm1 <= (r.op1 == OP_NOP) ? imm_t'($urandom) : r.imm1;
        pc1  <= r.pc1;
    endtask

    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("Timeout: the run went past %0d clock cycles.", MAX_CYCLES);
        stop_with_failure();
    end

    initial begin
        row_t idle;
        int   waited;
        idle = '0;
        void'($urandom(SEED));
        rst_n = 1'b0;
        drive_row(idle);
        build_table();

        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(negedge clk);
            check_bit("wb_valid0 in reset", 1'b0, wb_valid0);
            check_bit("wb_valid1 in reset", 1'b0, wb_valid1);
        end
        rst_n <= 1'b1;

        waited = 0;
        while (run_cycles == 0) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Timeout: the DUT never left reset.");
                stop_with_failure();
            end
        end

        // Row c is driven while row c-3 sits on the writeback ports.
        for (int c = 0; c < rows.size() + PIPE_DEPTH; c++) begin
            if (c >= PIPE_DEPTH) begin
                check_row(c - PIPE_DEPTH, rows[c - PIPE_DEPTH]);
            end else begin
                check_bit("wb_valid0 before first row", 1'b0, wb_valid0);
                check_bit("wb_valid1 before first row", 1'b0, wb_valid1);
            end
            if (c < rows.size()) drive_row(rows[c]);
            else                 drive_row(idle);
            @(negedge clk);
        end

        waited = 0;
        while (wb_valid0 || wb_valid1) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Timeout: the pipeline did not drain.");
                stop_with_failure();
            end
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
dual_issue_pkg.sv
stage_bus_if.sv
reg_file.sv
operand_forward.sv
alu.sv
execute_stage.sv
data_memory.sv
mem_wb_stage.sv
dual_issue_core.sv
tb_dual_issue.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and judge the result from sim.log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal -f tb.f --top-module tb_dual_issue \
    -o tb_dual_issue_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_dual_issue_sim > sim.log 2>&1 ; cat sim.log
! grep -q "TEST FAILED" sim.log && grep -q "TEST OK" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
